// File: verilog/sched_pkg.sv
package sched_pkg;

  // Fixed sizes of the scheduler
  localparam int if_count     = 3;
  localparam int core_count   = 4;
  localparam int slot_count   = 8;
  localparam int slot_w       = 4;
  localparam int core_id_w    = 2;
  localparam int if_id_w      = 2;
  localparam int line_count_w = 13;
  localparam int hash_w       = 32;
  localparam int ctrl_w       = 36;
  localparam int msg_type_w   = 4;

  // Seven in the top four bits of the line count
  localparam logic [line_count_w-1:0] drop_limit_reset = 13'd3584;

  typedef logic [hash_w-1:0]       hash_t;
  typedef logic [core_id_w-1:0]    core_id_t;
  typedef logic [if_id_w-1:0]      if_id_t;
  typedef logic [slot_w-1:0]       slot_t;
  typedef logic [core_count-1:0]   core_mask_t;
  typedef logic [line_count_w-1:0] line_count_t;
  typedef logic [ctrl_w-1:0]       ctrl_word_t;
  typedef logic [1+hash_w+core_id_w+slot_w-1:0] desc_t;
  typedef logic [31:0]             count_t;

  // Control message fields
  localparam int ctrl_type_lsb = 32;
  localparam int ctrl_slot_lsb = 16;

  typedef enum logic [msg_type_w-1:0] {
    slot_return = 4'd0,
    slot_init   = 4'd3
  } msg_type_e;

  // Host command fields
  localparam int host_wr_bit    = 31;
  localparam int host_if_bit    = 30;
  localparam int host_sched_bit = 29;
  localparam int host_idx_lsb   = 4;
  localparam int host_reg_w     = 4;

  // Core side register codes
  localparam logic [host_reg_w-1:0] reg_enabled    = 4'd0;
  localparam logic [host_reg_w-1:0] reg_income     = 4'd1;
  localparam logic [host_reg_w-1:0] reg_flush      = 4'd2;
  localparam logic [host_reg_w-1:0] reg_slot_count = 4'd3;
  // Interface side register codes
  localparam logic [host_reg_w-1:0] reg_drop_count = 4'd2;
  localparam logic [host_reg_w-1:0] reg_drop_limit = 4'd3;

  localparam logic [31:0] rd_default = 32'hFEFEFEFE;

endpackage

// File: verilog/sched_cfg_if.sv
`timescale 1ns/1ns

interface sched_cfg_if import sched_pkg::*; ();

  core_mask_t                  income_cores;
  core_mask_t                  slots_flush;
  logic [if_count-1:0]         rx_almost_full;
  slot_t [core_count-1:0]      slot_count;
  count_t [if_count-1:0]       drop_count;

  modport host (
    output income_cores, slots_flush, rx_almost_full,
    input  slot_count, drop_count
  );

  modport pool (
    input  slots_flush,
    output slot_count
  );

  modport alloc (
    input  income_cores, rx_almost_full,
    output drop_count
  );

endinterface

// File: verilog/slot_if.sv
`timescale 1ns/1ns

interface slot_if import sched_pkg::*; ();

  // Head of each core's free-slot list
  slot_t [core_count-1:0] slot_head;
  core_mask_t             slot_avail;

  // Pop removes the head of pop_core at the next edge
  logic                   pop;
  core_id_t               pop_core;

  modport pool (
    output slot_head, slot_avail,
    input  pop, pop_core
  );

  modport alloc (
    input  slot_head, slot_avail,
    output pop, pop_core
  );

endinterface

// File: verilog/slot_keeper.sv
`timescale 1ns/1ns

module slot_keeper import sched_pkg::*; (
  input  logic  clk,
  input  logic  rst_r,
  input  logic  flush,
  input  slot_t init_count,
  input  logic  init,
  input  slot_t slot_in,
  input  logic  enq,
  input  logic  pop,
  output slot_t head,
  output logic  avail,
  output slot_t count
);

  typedef logic [$clog2(slot_count)-1:0] ptr_t;

  slot_t mem [slot_count];
  ptr_t  rd_ptr;
  ptr_t  wr_ptr;
  slot_t init_clamp;
  logic  full;
  logic  do_enq;
  logic  do_pop;

  assign full   = (count == slot_t'(slot_count));
  assign avail  = (count != '0);
  assign head   = mem[rd_ptr];
  assign do_enq = enq && !full;
  assign do_pop = pop && avail;

  // Never load more slots than the buffer holds
  assign init_clamp = (init_count > slot_t'(slot_count)) ? slot_t'(slot_count) : init_count;

  // Init writes the whole list 1..slot_count, count limits what is visible
  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i < slot_count; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_enq) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init) begin
      rd_ptr <= '0;
      wr_ptr <= ptr_t'(init_clamp);
      count  <= init_clamp;
    end else begin
      if (do_enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_enq, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: verilog/slot_pool.sv
`timescale 1ns/1ns

module slot_pool import sched_pkg::*; (
  input  logic         clk,
  input  logic         rst_r,
  input  ctrl_word_t   ctrl_data,
  input  logic         ctrl_valid,
  input  core_id_t     ctrl_core,
  sched_cfg_if.pool    cfg,
  slot_if.pool         slots
);

  msg_type_e  msg_type;
  core_mask_t enq_v;
  core_mask_t init_v;
  slot_t      slot_r;

  assign msg_type = msg_type_e'(ctrl_data[ctrl_type_lsb +: msg_type_w]);

  // Per-core strobes, applied one edge later
  always_ff @(posedge clk) begin
    if (rst_r) begin
      enq_v  <= '0;
      init_v <= '0;
    end else begin
      for (int c = 0; c < core_count; c++) begin
        enq_v[c]  <= ctrl_valid && (msg_type == slot_return) && (ctrl_core == core_id_t'(c));
        init_v[c] <= ctrl_valid && (msg_type == slot_init) && (ctrl_core == core_id_t'(c));
      end
    end
  end

  // Slot to return, or number of slots for init
  always_ff @(posedge clk) begin
    slot_r <= ctrl_data[ctrl_slot_lsb +: slot_w];
  end

  for (genvar c = 0; c < core_count; c++) begin : g_core
    slot_keeper i_slot_keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .flush      (cfg.slots_flush[c]),
      .init_count (slot_r),
      .init       (init_v[c]),
      .slot_in    (slot_r),
      .enq        (enq_v[c]),
      .pop        (slots.pop && (slots.pop_core == core_id_t'(c))),
      .head       (slots.slot_head[c]),
      .avail      (slots.slot_avail[c]),
      .count      (cfg.slot_count[c])
    );
  end

endmodule

// File: verilog/host_cmd_regs.sv
`timescale 1ns/1ns

module host_cmd_regs import sched_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic [31:0]                  host_cmd,
  input  logic [31:0]                  host_cmd_wr_data,
  input  logic                         host_cmd_valid,
  output logic [31:0]                  host_cmd_rd_data,
  input  line_count_t [if_count-1:0]   rx_line_count,
  sched_cfg_if.host                    cfg
);

  logic                   wr_r;
  logic                   if_sel_r;
  logic [host_reg_w-1:0]  reg_r;
  core_id_t               core_idx_r;
  if_id_t                 if_idx_r;
  logic [31:0]            wr_data_r;
  logic [31:0]            rd_next;
  core_mask_t             enabled_cores;
  core_mask_t             income_cores;
  core_mask_t             slots_flush;
  line_count_t            drop_limit;
  line_count_t [if_count-1:0] line_r;
  logic [if_count-1:0]    almost_full;

  // Command fields are held so the readback stays on the last command
  always_ff @(posedge clk) begin
    if (host_cmd_valid) begin
      if_sel_r   <= host_cmd[host_if_bit];
      reg_r      <= host_cmd[host_reg_w-1:0];
      core_idx_r <= host_cmd[host_idx_lsb +: core_id_w];
      if_idx_r   <= host_cmd[host_idx_lsb +: if_id_w];
      wr_data_r  <= host_cmd_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r <= 1'b0;
    end else begin
      wr_r <= host_cmd_valid && host_cmd[host_wr_bit] && host_cmd[host_sched_bit];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= drop_limit_reset;
    end else begin
      slots_flush <= '0;
      if (wr_r && !if_sel_r) begin
        case (reg_r)
          reg_enabled: begin
            // A core taken out of service stops receiving too
            enabled_cores <= wr_data_r[core_count-1:0];
            income_cores  <= income_cores & wr_data_r[core_count-1:0];
          end
          reg_income: income_cores <= wr_data_r[core_count-1:0] & enabled_cores;
          reg_flush:  slots_flush  <= wr_data_r[core_count-1:0];
          default:    ;
        endcase
      end else if (wr_r && (reg_r == reg_drop_limit)) begin
        drop_limit <= wr_data_r[line_count_w-1:0];
      end
    end
  end

  // Line count sampled, then compared against the limit
  always_ff @(posedge clk) begin
    line_r <= rx_line_count;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
    end else begin
      for (int i = 0; i < if_count; i++) begin
        almost_full[i] <= (line_r[i] >= drop_limit);
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_next <= rd_default;
    if (!if_sel_r) begin
      case (reg_r)
        reg_enabled:    rd_next <= 32'(enabled_cores);
        reg_income:     rd_next <= 32'(income_cores);
        reg_slot_count: rd_next <= 32'(cfg.slot_count[core_idx_r]);
        default:        ;
      endcase
    end else if ((reg_r == reg_drop_count) && (if_idx_r < if_id_t'(if_count))) begin
      rd_next <= cfg.drop_count[if_idx_r];
    end
    host_cmd_rd_data <= rd_next;
  end

  assign cfg.income_cores   = income_cores;
  assign cfg.slots_flush    = slots_flush;
  assign cfg.rx_almost_full = almost_full;

endmodule

// File: verilog/desc_allocator.sv
`timescale 1ns/1ns

module desc_allocator import sched_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_r,
  input  hash_t [if_count-1:0]   rx_hash,
  input  logic [if_count-1:0]    rx_hash_valid,
  output logic [if_count-1:0]    rx_hash_ready,
  output desc_t [if_count-1:0]   desc_data,
  output logic [if_count-1:0]    desc_valid,
  input  logic [if_count-1:0]    desc_ready,
  sched_cfg_if.alloc             cfg,
  slot_if.alloc                  slots
);

  logic [if_count-1:0]  req;
  logic [if_count-1:0]  grant;
  if_id_t               grant_id;
  logic                 grant_v;
  logic [if_count-1:0]  grant_r;
  if_id_t               grant_id_r;
  logic                 grant_v_r;
  if_id_t               last_id;
  core_id_t             dest_core_r;
  logic                 core_ok;
  logic                 alloc;
  logic                 drop;
  desc_t                desc;
  count_t [if_count-1:0] drop_cnt;

  // An interface granted last cycle is still being decided, so skip it
  assign req = rx_hash_valid & desc_ready & ~grant_r;

  // Round robin, starting after the last winner
  always_comb begin
    int idx;
    grant    = '0;
    grant_id = '0;
    grant_v  = 1'b0;
    for (int k = 1; k <= if_count; k++) begin
      idx = (int'(last_id) + k) % if_count;
      if (!grant_v && req[idx]) begin
        grant[idx] = 1'b1;
        grant_id   = if_id_t'(idx);
        grant_v    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_r     <= '0;
      grant_id_r  <= '0;
      grant_v_r   <= 1'b0;
      last_id     <= if_id_t'(if_count - 1);
      dest_core_r <= '0;
    end else begin
      grant_r     <= grant;
      grant_id_r  <= grant_id;
      grant_v_r   <= grant_v;
      dest_core_r <= rx_hash[grant_id][core_id_w-1:0];
      if (grant_v) begin
        last_id <= grant_id;
      end
    end
  end

  // Allocate if the core takes traffic and has a slot, else drop when nearly full
  assign core_ok = cfg.income_cores[dest_core_r] && slots.slot_avail[dest_core_r];
  assign alloc   = grant_v_r && core_ok;
  assign drop    = grant_v_r && !core_ok && cfg.rx_almost_full[grant_id_r];

  assign desc = {drop, rx_hash[grant_id_r], dest_core_r, slots.slot_head[dest_core_r]};

  assign desc_data     = {if_count{desc}};
  assign desc_valid    = (alloc || drop) ? grant_r : '0;
  assign rx_hash_ready = (alloc || drop) ? grant_r : '0;

  assign slots.pop      = alloc;
  assign slots.pop_core = dest_core_r;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_cnt <= '0;
    end else if (drop) begin
      drop_cnt[grant_id_r] <= drop_cnt[grant_id_r] + 1'b1;
    end
  end

  assign cfg.drop_count = drop_cnt;

endmodule

// File: verilog/scheduler_top.sv
`timescale 1ns/1ns

module scheduler_top import sched_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_r,

  // Flow hashes from the receive interfaces
  input  hash_t [if_count-1:0]        rx_hash,
  input  logic [if_count-1:0]         rx_hash_valid,
  output logic [if_count-1:0]         rx_hash_ready,
  input  line_count_t [if_count-1:0]  rx_line_count,

  // Descriptor pushes into the external FIFOs
  output desc_t [if_count-1:0]        desc_data,
  output logic [if_count-1:0]         desc_valid,
  input  logic [if_count-1:0]         desc_ready,

  // Control messages from the cores
  input  ctrl_word_t                  ctrl_data,
  input  logic                        ctrl_valid,
  input  core_id_t                    ctrl_core,

  // Host command port
  input  logic [31:0]                 host_cmd,
  input  logic [31:0]                 host_cmd_wr_data,
  input  logic                        host_cmd_valid,
  output logic [31:0]                 host_cmd_rd_data
);

  sched_cfg_if cfg ();
  slot_if      slots ();

  slot_pool i_slot_pool (
    .clk        (clk),
    .rst_r      (rst_r),
    .ctrl_data  (ctrl_data),
    .ctrl_valid (ctrl_valid),
    .ctrl_core  (ctrl_core),
    .cfg        (cfg),
    .slots      (slots)
  );

  host_cmd_regs i_host_cmd_regs (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data),
    .rx_line_count    (rx_line_count),
    .cfg              (cfg)
  );

  desc_allocator i_desc_allocator (
    .clk           (clk),
    .rst_r         (rst_r),
    .rx_hash       (rx_hash),
    .rx_hash_valid (rx_hash_valid),
    .rx_hash_ready (rx_hash_ready),
    .desc_data     (desc_data),
    .desc_valid    (desc_valid),
    .desc_ready    (desc_ready),
    .cfg           (cfg),
    .slots         (slots)
  );

endmodule

// File: sim/scheduler_tb.sv
`timescale 1ns/1ns

module scheduler_tb import sched_pkg::*; ();

  logic                       clk;
  logic                       rst_r;
  hash_t [if_count-1:0]       rx_hash;
  logic [if_count-1:0]        rx_hash_valid;
  logic [if_count-1:0]        rx_hash_ready;
  line_count_t [if_count-1:0] rx_line_count;
  desc_t [if_count-1:0]       desc_data;
  logic [if_count-1:0]        desc_valid;
  logic [if_count-1:0]        desc_ready;
  ctrl_word_t                 ctrl_data;
  logic                       ctrl_valid;
  core_id_t                   ctrl_core;
  logic [31:0]                host_cmd;
  logic [31:0]                host_cmd_wr_data;
  logic                       host_cmd_valid;
  logic [31:0]                host_cmd_rd_data;

  // Operations loaded from the vector file
  string       op_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];
  logic [31:0] d_q[$];

  int cycle_count = 0;
  int cycle_limit = 32'h7FFFFFFF;

  scheduler_top i_scheduler_top (
    .clk              (clk),
    .rst_r            (rst_r),
    .rx_hash          (rx_hash),
    .rx_hash_valid    (rx_hash_valid),
    .rx_hash_ready    (rx_hash_ready),
    .rx_line_count    (rx_line_count),
    .desc_data        (desc_data),
    .desc_valid       (desc_valid),
    .desc_ready       (desc_ready),
    .ctrl_data        (ctrl_data),
    .ctrl_valid       (ctrl_valid),
    .ctrl_core        (ctrl_core),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: no progress after %0d cycles", cycle_count);
      $display("Checks failed");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          r;
    int          nargs;
    string       op;
    string       rest;
    logic [31:0] args[4];
    fd = $fopen("sim/scheduler_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file sim/scheduler_vectors.txt");
      $display("Checks failed");
      $fatal(1, "No vectors");
    end
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op[0] == "#") begin
        // Rest of a comment line
        r = $fgets(rest, fd);
      end else begin
        case (op)
          "W", "R", "L", "D", "O", "S": nargs = 2;
          "C":     nargs = 3;
          "E":     nargs = 4;
          "I":     nargs = 1;
          default: nargs = -1;
        endcase
        if (nargs < 0) begin
          $display("Unknown operation %s in the vector file", op);
          $display("Checks failed");
          $fatal(1, "Bad vector file");
        end
        for (int k = 0; k < 4; k++) begin
          args[k] = '0;
          if (k < nargs) begin
            r = $fscanf(fd, " %h", args[k]);
            if (r != 1) begin
              $display("Missing field after operation %s in the vector file", op);
              $display("Checks failed");
              $fatal(1, "Bad vector file");
            end
          end
        end
        op_q.push_back(op);
        a_q.push_back(args[0]);
        b_q.push_back(args[1]);
        c_q.push_back(args[2]);
        d_q.push_back(args[3]);
      end
    end
    $fclose(fd);
  endtask

  task automatic host_write(input logic [31:0] cmd, input logic [31:0] data);
    host_cmd         = cmd;
    host_cmd_wr_data = data;
    host_cmd_valid   = 1'b1;
    @(posedge clk);
    #1;
    host_cmd_valid   = 1'b0;
  endtask

  // Read data is registered three edges after the command
  task automatic host_read(input string name, input logic [31:0] cmd, input logic [31:0] exp);
    host_cmd       = cmd;
    host_cmd_valid = 1'b1;
    @(posedge clk);
    #1;
    host_cmd_valid = 1'b0;
    @(posedge clk);
    @(posedge clk);
    #1;
    compare(name, exp, host_cmd_rd_data);
  endtask

  task automatic send_ctrl(input logic [31:0] core, input logic [31:0] mtype,
                           input logic [31:0] slot);
    ctrl_data        = '0;
    ctrl_data[35:32] = mtype[3:0];
    ctrl_data[19:16] = slot[3:0];
    ctrl_core        = core_id_t'(core);
    ctrl_valid       = 1'b1;
    @(posedge clk);
    #1;
    ctrl_valid       = 1'b0;
  endtask

  task automatic stay_quiet(input string name, input if_id_t idx, input logic [31:0] cycles);
    repeat (cycles) begin
      @(negedge clk);
      compare(name, 32'd0, 32'(desc_valid[idx]));
      compare(name, 32'd0, 32'(rx_hash_ready[idx]));
      @(posedge clk);
      #1;
    end
  endtask

  // Descriptor layout is drop, hash, core, slot from the top bit down
  task automatic wait_desc(input string name, input if_id_t idx, input logic [31:0] drop,
                           input logic [31:0] core, input logic [31:0] slot);
    desc_t d;
    logic  seen;
    logic  rdy;
    seen = 1'b0;
    rdy  = 1'b0;
    d    = '0;
    while (!seen) begin
      @(negedge clk);
      if (desc_valid[idx]) begin
        seen = 1'b1;
        d    = desc_data[idx];
        rdy  = rx_hash_ready[idx];
      end
      @(posedge clk);
      #1;
    end
    compare(name, 32'd1, 32'(rdy));
    compare(name, drop, 32'(d[38]));
    compare(name, rx_hash[idx], d[37:6]);
    compare(name, core, 32'(d[5:4]));
    if (drop == 32'd0) begin
      compare(name, slot, 32'(d[3:0]));
    end
    rx_hash_valid[idx] = 1'b0;
  endtask

  task automatic run_op(input int n);
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    a    = a_q[n];
    b    = b_q[n];
    name = $sformatf("vector %0d %s", n, op_q[n]);
    if (op_q[n] == "W") begin
      host_write(a, b);
    end else if (op_q[n] == "R") begin
      host_read(name, a, b);
    end else if (op_q[n] == "C") begin
      send_ctrl(a, b, c_q[n]);
    end else if (op_q[n] == "L") begin
      rx_line_count[if_id_t'(a)] = line_count_t'(b);
    end else if (op_q[n] == "D") begin
      desc_ready[if_id_t'(a)] = b[0];
    end else if (op_q[n] == "O") begin
      rx_hash[if_id_t'(a)]       = b;
      rx_hash_valid[if_id_t'(a)] = 1'b1;
    end else if (op_q[n] == "S") begin
      stay_quiet(name, if_id_t'(a), b);
    end else if (op_q[n] == "E") begin
      wait_desc(name, if_id_t'(a), b, c_q[n], d_q[n]);
    end else if (op_q[n] == "I") begin
      repeat (a) @(posedge clk);
      #1;
    end
  endtask

  initial begin
    clk              = 1'b0;
    rst_r            = 1'b1;
    rx_hash          = '0;
    rx_hash_valid    = '0;
    rx_line_count    = '0;
    desc_ready       = '1;
    ctrl_data        = '0;
    ctrl_valid       = 1'b0;
    ctrl_core        = '0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    load_vectors();
    // Budget per operation plus reset
    cycle_limit = 64 * op_q.size() + 16;
    repeat (5) @(posedge clk);
    #1;
    rst_r = 1'b0;
    for (int n = 0; n < op_q.size(); n++) begin
      run_op(n);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: scheduler.f
verilog/sched_pkg.sv
verilog/sched_cfg_if.sv
verilog/slot_if.sv
verilog/slot_keeper.sv
verilog/slot_pool.sv
verilog/host_cmd_regs.sv
verilog/desc_allocator.sv
verilog/scheduler_top.sv
sim/scheduler_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module scheduler_tb -f scheduler.f \
  -Mdir obj_dir -o scheduler_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/scheduler_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: sim/scheduler_vectors.txt
# Hex fields. W cmd data | R cmd expected | C core type slot | L if lines | D if ready
# O if hash | S if cycles (quiet) | E if drop core slot | I cycles (idle)
# Reset state
R 20000000 00000000
R 20000001 00000000
R 60000002 00000000
R 60000012 00000000
R 60000022 00000000
R 20000003 00000000
R 20000005 FEFEFEFE
# Enabled and income masks
W A0000000 00000005
W A0000001 0000000F
R 20000001 00000005
R 20000000 00000005
W A0000000 00000001
R 20000001 00000001
# Three slots on core 0, used in order
C 0 3 3
R 20000003 00000003
O 0 9E3779B4
E 0 0 0 1
O 0 5A5A5A58
E 0 0 0 2
O 0 0F1E2D3C
E 0 0 0 3
R 20000003 00000000
C 0 0 2
O 0 76543210
E 0 0 0 2
# Drop on a nearly full interface
W E0000003 00000064
L 2 0080
I 2
O 2 13579BDC
E 2 1 0 0
R 60000022 00000001
R 60000002 00000000
L 2 0000
# Stall until a slot comes back
O 0 2468ACE0
S 0 10
C 0 0 5
E 0 0 0 5
# Back-pressure on interface 1 toward core 2
W A0000000 00000005
W A0000001 00000005
C 2 3 2
D 1 0
O 1 00000006
S 1 8
D 1 1
E 1 0 2 1
# Flush of core 0
C 0 3 4
R 20000003 00000004
W A0000002 00000001
I 1
R 20000003 00000000
